//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t reset_pc = '0;

    // rv32i major opcodes
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    typedef enum logic [2:0] {
        op_alu_imm,
        op_alu_reg,
        op_lui,
        op_branch,
        op_jal,
        op_load,
        op_store,
        op_nop
    } op_e;

    typedef enum logic {
        alu_add,
        alu_sub
    } alu_e;

    typedef struct packed {
        op_e       op;
        alu_e      alu;
        logic      branch_ne;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        word_t     pc;
    } decoded_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      wen;
        word_t     value;
        logic      taken;
        word_t     target;
        word_t     pc;
    } exec_result_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic            clock,
    input  logic            i_rst,
    input  logic            i_pc_update,
    input  core_pkg::word_t i_next_pc,
    input  logic            i_imem_valid,
    input  core_pkg::word_t i_imem_data,
    output logic            o_imem_req,
    output core_pkg::word_t o_imem_addr,
    output logic            o_valid,
    output core_pkg::word_t o_instr,
    output core_pkg::word_t o_pc
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_mem,
        issue
    } state_e;

    state_e state;
    word_t  pc;

    assign o_imem_addr = pc;
    assign o_pc        = pc;

    always_ff @(posedge clock) begin
        if (i_rst) begin
            state      <= issue;
            pc         <= reset_pc;
            o_imem_req <= 1'b0;
            o_valid    <= 1'b0;
        end else begin
            o_imem_req <= 1'b0;
            o_valid    <= 1'b0;
            case (state)
                // first request out of reset
                issue: begin
                    o_imem_req <= 1'b1;
                    state      <= wait_mem;
                end
                wait_mem: begin
                    if (i_imem_valid) begin
                        o_instr <= i_imem_data;
                        o_valid <= 1'b1;
                        state   <= idle;
                    end
                end
                idle: begin
                    // writeback hands over the next pc
                    if (i_pc_update) begin
                        pc         <= i_next_pc;
                        o_imem_req <= 1'b1;
                        state      <= wait_mem;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
`default_nettype none

module decode_unit (
    input  logic               clock,
    input  logic               i_rst,
    input  logic               i_valid,
    input  core_pkg::word_t    i_instr,
    input  core_pkg::word_t    i_pc,
    output logic               o_valid,
    output core_pkg::decoded_t o_dec
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    decoded_t   dec_next;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        dec_next.op        = op_nop;
        dec_next.alu       = alu_add;
        dec_next.branch_ne = funct3[0];
        dec_next.rd        = i_instr[11:7];
        dec_next.rs1       = i_instr[19:15];
        dec_next.rs2       = i_instr[24:20];
        dec_next.imm       = imm_i;
        dec_next.pc        = i_pc;
        case (opcode)
            opc_op_imm: begin
                if (funct3 == 3'b000) begin
                    dec_next.op = op_alu_imm;
                end
            end
            opc_op: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    dec_next.op = op_alu_reg;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    dec_next.op  = op_alu_reg;
                    dec_next.alu = alu_sub;
                end
            end
            opc_lui: begin
                dec_next.op  = op_lui;
                dec_next.imm = imm_u;
            end
            opc_branch: begin
                // beq and bne only
                if (funct3[2:1] == 2'b00) begin
                    dec_next.op = op_branch;
                end
                dec_next.imm = imm_b;
            end
            opc_jal: begin
                dec_next.op  = op_jal;
                dec_next.imm = imm_j;
            end
            opc_load: begin
                if (funct3 == 3'b010) begin
                    dec_next.op = op_load;
                end
            end
            opc_store: begin
                if (funct3 == 3'b010) begin
                    dec_next.op = op_store;
                end
                dec_next.imm = imm_s;
            end
            default: dec_next.op = op_nop;
        endcase
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
        if (i_valid) begin
            o_dec <= dec_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

module register_file (
    input  logic                clock,
    input  core_pkg::reg_addr_t i_rs1,
    input  core_pkg::reg_addr_t i_rs2,
    input  logic                i_wen,
    input  core_pkg::reg_addr_t i_rd,
    input  core_pkg::word_t     i_wdata,
    output core_pkg::word_t     o_rs1_data,
    output core_pkg::word_t     o_rs2_data
);
    import core_pkg::*;

    word_t regs [reg_count];

    // x0 reads as zero whatever the array holds
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clock) begin
        if (i_wen && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`default_nettype none

module execute_unit (
    input  logic                   clock,
    input  logic                   i_rst,
    input  logic                   i_valid,
    input  core_pkg::decoded_t     i_dec,
    input  core_pkg::word_t        i_rs1_data,
    input  core_pkg::word_t        i_rs2_data,
    input  logic                   i_dmem_valid,
    input  core_pkg::word_t        i_dmem_rdata,
    output logic                   o_dmem_req,
    output core_pkg::mem_req_t     o_dmem,
    output logic                   o_valid,
    output core_pkg::exec_result_t o_res
);
    import core_pkg::*;

    typedef enum logic {
        idle,
        wait_mem
    } state_e;

    state_e       state;
    word_t        alu_b;
    word_t        alu_out;
    logic         is_mem;
    exec_result_t res_next;

    assign alu_b   = (i_dec.op == op_alu_reg) ? i_rs2_data : i_dec.imm;
    assign alu_out = (i_dec.alu == alu_sub) ? i_rs1_data - alu_b : i_rs1_data + alu_b;
    assign is_mem  = (i_dec.op == op_load) || (i_dec.op == op_store);

    always_comb begin
        res_next.rd     = i_dec.rd;
        res_next.pc     = i_dec.pc;
        res_next.target = i_dec.pc + i_dec.imm;
        res_next.wen    = 1'b0;
        res_next.taken  = 1'b0;
        res_next.value  = alu_out;
        case (i_dec.op)
            op_alu_imm, op_alu_reg, op_load: res_next.wen = 1'b1;
            op_lui: begin
                res_next.wen   = 1'b1;
                res_next.value = i_dec.imm;
            end
            op_jal: begin
                res_next.wen   = 1'b1;
                res_next.taken = 1'b1;
                res_next.value = i_dec.pc + 32'd4;
            end
            // equality flipped for bne
            op_branch: res_next.taken = (i_rs1_data == i_rs2_data) ^ i_dec.branch_ne;
            default: res_next.wen = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            state      <= idle;
            o_valid    <= 1'b0;
            o_dmem_req <= 1'b0;
        end else begin
            o_valid    <= 1'b0;
            o_dmem_req <= 1'b0;
            case (state)
                idle: begin
                    if (i_valid) begin
                        o_res <= res_next;
                        if (is_mem) begin
                            o_dmem_req   <= 1'b1;
                            o_dmem.write <= (i_dec.op == op_store);
                            o_dmem.addr  <= alu_out;
                            o_dmem.wdata <= i_rs2_data;
                            state        <= wait_mem;
                        end else begin
                            o_valid <= 1'b1;
                        end
                    end
                end
                wait_mem: begin
                    if (i_dmem_valid) begin
                        // only a load writes a register
                        if (o_res.wen) begin
                            o_res.value <= i_dmem_rdata;
                        end
                        o_valid <= 1'b1;
                        state   <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/writeback_unit.sv
`default_nettype none

module writeback_unit (
    input  logic                   clock,
    input  logic                   i_rst,
    input  logic                   i_valid,
    input  core_pkg::exec_result_t i_res,
    output logic                   o_rf_wen,
    output core_pkg::reg_addr_t    o_rf_rd,
    output core_pkg::word_t        o_rf_wdata,
    output logic                   o_pc_update,
    output core_pkg::word_t        o_next_pc
);

    always_ff @(posedge clock) begin
        if (i_rst) begin
            o_rf_wen    <= 1'b0;
            o_pc_update <= 1'b0;
        end else begin
            o_rf_wen    <= i_valid && i_res.wen;
            o_pc_update <= i_valid;
        end
        if (i_valid) begin
            o_rf_rd    <= i_res.rd;
            o_rf_wdata <= i_res.value;
            // redirect on taken branch or jal
            if (i_res.taken) begin
                o_next_pc <= i_res.target;
            end else begin
                o_next_pc <= i_res.pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_core_top.sv
`default_nettype none

module rv_core_top (
    input  logic               clock,
    input  logic               i_rst,
    input  logic               i_imem_valid,
    input  core_pkg::word_t    i_imem_data,
    input  logic               i_dmem_valid,
    input  core_pkg::word_t    i_dmem_rdata,
    output logic               o_imem_req,
    output core_pkg::word_t    o_imem_addr,
    output logic               o_dmem_req,
    output core_pkg::mem_req_t o_dmem
);
    import core_pkg::*;

    logic         fetch_valid;
    word_t        fetch_instr;
    word_t        fetch_pc;
    logic         dec_valid;
    decoded_t     dec;
    word_t        rs1_data;
    word_t        rs2_data;
    logic         exe_valid;
    exec_result_t exe_res;
    logic         rf_wen;
    reg_addr_t    rf_rd;
    word_t        rf_wdata;
    logic         pc_update;
    word_t        next_pc;

    fetch_unit u_fetch (
        .clock        (clock),
        .i_rst        (i_rst),
        .i_pc_update  (pc_update),
        .i_next_pc    (next_pc),
        .i_imem_valid (i_imem_valid),
        .i_imem_data  (i_imem_data),
        .o_imem_req   (o_imem_req),
        .o_imem_addr  (o_imem_addr),
        .o_valid      (fetch_valid),
        .o_instr      (fetch_instr),
        .o_pc         (fetch_pc)
    );

    decode_unit u_decode (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_valid (fetch_valid),
        .i_instr (fetch_instr),
        .i_pc    (fetch_pc),
        .o_valid (dec_valid),
        .o_dec   (dec)
    );

    // read ports follow the registered decode
    register_file u_regs (
        .clock      (clock),
        .i_rs1      (dec.rs1),
        .i_rs2      (dec.rs2),
        .i_wen      (rf_wen),
        .i_rd       (rf_rd),
        .i_wdata    (rf_wdata),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_unit u_execute (
        .clock        (clock),
        .i_rst        (i_rst),
        .i_valid      (dec_valid),
        .i_dec        (dec),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_dmem_valid (i_dmem_valid),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_req   (o_dmem_req),
        .o_dmem       (o_dmem),
        .o_valid      (exe_valid),
        .o_res        (exe_res)
    );

    writeback_unit u_writeback (
        .clock       (clock),
        .i_rst       (i_rst),
        .i_valid     (exe_valid),
        .i_res       (exe_res),
        .o_rf_wen    (rf_wen),
        .o_rf_rd     (rf_rd),
        .o_rf_wdata  (rf_wdata),
        .o_pc_update (pc_update),
        .o_next_pc   (next_pc)
    );

endmodule

`default_nettype wire

//--- testbench/tb_core.sv
`default_nettype none

module tb_core;
    import core_pkg::*;

    typedef struct packed {
        word_t instr;
        word_t next_pc;
    } prog_entry_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_entry_t;

    localparam int    prog_len    = 25;
    localparam int    store_count = 8;
    localparam int    dmem_words  = 16;
    localparam word_t dmem_base   = 32'h0000_0100;
    localparam int    wait_limit  = 200;

    logic     clock = 1'b0;
    logic     i_rst;
    logic     i_imem_valid = 1'b0;
    word_t    i_imem_data  = '0;
    logic     i_dmem_valid = 1'b0;
    word_t    i_dmem_rdata = '0;
    logic     o_imem_req;
    word_t    o_imem_addr;
    logic     o_dmem_req;
    mem_req_t o_dmem;

    prog_entry_t  prog [prog_len];
    store_entry_t stores [store_count];
    word_t        dmem [dmem_words];
    int           prog_fill;
    int           seed = 11355;
    int           imem_wait = 0;
    int           fetch_idx = 0;
    word_t        fetch_expect = reset_pc;
    int           dmem_wait = 0;
    int           dmem_idx = 0;
    mem_req_t     dreq;

    rv_core_top dut0 (
        .clock        (clock),
        .i_rst        (i_rst),
        .i_imem_valid (i_imem_valid),
        .i_imem_data  (i_imem_data),
        .i_dmem_valid (i_dmem_valid),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_req   (o_imem_req),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_req   (o_dmem_req),
        .o_dmem       (o_dmem)
    );

    initial begin
        forever #20 clock = ~clock;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    function automatic int draw_latency();
        return 1 + int'($unsigned($random(seed)) % 32'd4);
    endfunction

    // instruction encoders
    function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                    input int rd);
        return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opc_op};
    endfunction

    function automatic word_t enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic word_t enc_b(input int off, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t enc_u(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], opc_lui};
    endfunction

    function automatic word_t enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
    endfunction

    task automatic add_seq(input word_t instr);
        prog[prog_fill].instr   = instr;
        prog[prog_fill].next_pc = word_t'(4 * (prog_fill + 1));
        prog_fill++;
    endtask

    task automatic add_jump(input word_t instr, input word_t target);
        prog[prog_fill].instr   = instr;
        prog[prog_fill].next_pc = target;
        prog_fill++;
    endtask

    task automatic load_program();
        prog_fill = 0;
        add_seq(enc_i(256, 0, 3'b000, 6, opc_op_imm));
        add_seq(enc_i(5, 0, 3'b000, 1, opc_op_imm));
        add_seq(enc_i(-3, 0, 3'b000, 2, opc_op_imm));
        add_seq(enc_r(7'b0000000, 2, 1, 3));
        add_seq(enc_r(7'b0100000, 1, 2, 4));
        add_seq(enc_u(32'hABCDE, 5));
        add_seq(enc_s(0, 3, 6));
        add_seq(enc_s(4, 4, 6));
        add_seq(enc_s(8, 5, 6));
        add_seq(enc_i(7, 0, 3'b000, 0, opc_op_imm));
        add_seq(enc_s(12, 0, 6));
        // beq taken over the marker at 0x30
        add_jump(enc_b(8, 1, 1, 3'b000), 32'h34);
        add_seq(enc_i(100, 1, 3'b000, 1, opc_op_imm));
        add_seq(enc_b(8, 1, 1, 3'b001));
        add_seq(enc_i(10, 2, 3'b000, 2, opc_op_imm));
        add_seq(enc_s(16, 1, 6));
        add_seq(enc_s(20, 2, 6));
        add_jump(enc_j(8, 8), 32'h4C);
        add_seq(enc_i(1, 1, 3'b000, 1, opc_op_imm));
        add_seq(enc_s(24, 8, 6));
        add_seq(enc_i(32, 6, 3'b010, 9, opc_load));
        add_seq(enc_r(7'b0000000, 1, 9, 10));
        add_seq(enc_i(64, 6, 3'b000, 11, opc_op_imm));
        add_seq(enc_s(-4, 10, 11));
        // park on a self loop
        add_jump(enc_j(0, 0), 32'h60);
    endtask

    task automatic load_tables();
        for (int k = 0; k < dmem_words; k++) begin
            dmem[k] = (dmem_base + word_t'(4 * k)) ^ 32'h5A5A_0000;
        end
        dmem[8] = 32'hFFFF_FFFE;
        stores[0] = {32'h0000_0100, 32'h0000_0002};
        stores[1] = {32'h0000_0104, 32'hFFFF_FFF8};
        stores[2] = {32'h0000_0108, 32'hABCD_E000};
        stores[3] = {32'h0000_010C, 32'h0000_0000};
        stores[4] = {32'h0000_0110, 32'h0000_0005};
        stores[5] = {32'h0000_0114, 32'h0000_0007};
        stores[6] = {32'h0000_0118, 32'h0000_0048};
        // 0xFFFFFFFE + 5 wraps to 3
        stores[7] = {32'h0000_013C, 32'h0000_0003};
    endtask

    // instruction memory that also checks the fetch sequence
    always @(negedge clock) begin
        i_imem_valid = 1'b0;
        if (!i_rst && o_imem_req) begin
            check("o_imem_addr", o_imem_addr, fetch_expect);
            fetch_idx = int'(o_imem_addr >> 2);
            if (fetch_idx >= prog_len) begin
                stop_run("instruction fetch outside the program");
            end
            fetch_expect = prog[fetch_idx].next_pc;
            imem_wait    = draw_latency();
        end
        if (imem_wait != 0) begin
            imem_wait = imem_wait - 1;
            if (imem_wait == 0) begin
                i_imem_data  = prog[fetch_idx].instr;
                i_imem_valid = 1'b1;
            end
        end
    end

    always @(negedge clock) begin
        i_dmem_valid = 1'b0;
        if (!i_rst && o_dmem_req) begin
            if (o_dmem.addr < dmem_base || o_dmem.addr[1:0] != 2'b00 ||
                o_dmem.addr >= dmem_base + word_t'(4 * dmem_words)) begin
                stop_run("data access outside the data memory");
            end
            dreq      = o_dmem;
            dmem_idx  = int'((o_dmem.addr - dmem_base) >> 2);
            dmem_wait = draw_latency();
        end
        if (dmem_wait != 0) begin
            dmem_wait = dmem_wait - 1;
            if (dmem_wait == 0) begin
                if (dreq.write) begin
                    dmem[dmem_idx] = dreq.wdata;
                end else begin
                    i_dmem_rdata = dmem[dmem_idx];
                end
                i_dmem_valid = 1'b1;
            end
        end
    end

    task automatic wait_for_store();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!(o_dmem_req && o_dmem.write)) begin
            if (cycles == wait_limit) begin
                stop_run("timeout while waiting for a store request");
            end
            cycles++;
            @(negedge clock);
        end
    endtask

    initial begin
        i_rst = 1'b1;
        load_program();
        load_tables();
        for (int k = 0; k < 5; k++) begin
            @(negedge clock);
            check("o_imem_req", word_t'(o_imem_req), 32'd0);
            check("o_dmem_req", word_t'(o_dmem_req), 32'd0);
        end
        i_rst = 1'b0;
        @(negedge clock);
        check("o_imem_req", word_t'(o_imem_req), 32'd1);
        check("o_imem_addr", o_imem_addr, reset_pc);
        for (int k = 0; k < store_count; k++) begin
            wait_for_store();
            check("o_dmem.addr", o_dmem.addr, stores[k].addr);
            check("o_dmem.wdata", o_dmem.wdata, stores[k].data);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/register_file.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/rv_core_top.sv
testbench/tb_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing -f vlog.f --top-module tb_core \
        --Mdir "$build_dir" -o tb_core; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_core" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -qx "Result: PASSED" "$log_file"; then
    exit 0
fi
exit 1
